//--- hdl/mmu_pkg.sv
package mmu_pkg;

    // Byte address and cache line geometry
    localparam int ADDR_WIDTH      = 32;
    localparam int LINE_BYTES_LOG2 = 4;
    localparam int LINE_WIDTH      = 128;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LINE_WIDTH-1:0] line_t;

    // Which cache the outstanding memory read belongs to
    typedef enum logic {
        OWNER_DCACHE,
        OWNER_ICACHE
    } req_owner_e;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        DC_REQ,
        DC_WAIT,
        IC_REQ,
        IC_WAIT
    } mmu_state_e;

    // Clear the byte offset inside a line
    function automatic addr_t line_align(input addr_t addr);
        addr_t aligned;
        aligned = addr;
        aligned[LINE_BYTES_LOG2-1:0] = '0;
        return aligned;
    endfunction

endpackage

//--- hdl/mmu_miss_queue.sv
`timescale 1ns/100ps

module mmu_miss_queue
    import mmu_pkg::*;
#(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  miss_i,
    input  addr_t miss_addr_i,
    input  logic  pop_i,
    output logic  pending_o,
    output addr_t head_addr_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    addr_t            entries_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_next;
    logic [CNT_W-1:0] count_q;
    addr_t            line_addr;
    logic             merge;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign line_addr   = line_align(miss_addr_i);
    assign rd_ptr_next = ptr_inc(rd_ptr_q);
    assign pending_o   = (count_q != '0);

    // Same-line check against every live entry
    always_comb begin
        int offset;
        merge = 1'b0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (i >= int'(rd_ptr_q)) begin
                offset = i - int'(rd_ptr_q);
            end else begin
                offset = i + QUEUE_DEPTH - int'(rd_ptr_q);
            end
            if (offset < int'(count_q) && entries_q[i] == line_addr) begin
                merge = 1'b1;
            end
        end
    end

    // Full queue drops the miss, the cache retries
    assign push = miss_i && !merge && (count_q != CNT_W'(QUEUE_DEPTH));
    assign pop  = pop_i && pending_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_next;
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            entries_q[wr_ptr_q] <= line_addr;
        end
        // Head keeps its old value once the queue drains
        if (pop && count_q > CNT_W'(1)) begin
            head_addr_o <= entries_q[rd_ptr_next];
        end else if (push && (count_q == '0 || (pop && count_q == CNT_W'(1)))) begin
            head_addr_o <= line_addr;
        end
    end

endmodule

//--- hdl/mmu_lru_tracker.sv
`timescale 1ns/100ps

module mmu_lru_tracker #(
    parameter int NUM_WAYS = 4
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        touch_i,
    input  logic [$clog2(NUM_WAYS)-1:0] touch_way_i,
    output logic [$clog2(NUM_WAYS)-1:0] victim_way_o
);

    localparam int WAY_W    = $clog2(NUM_WAYS);
    localparam int LRU_BITS = NUM_WAYS * (NUM_WAYS - 1) / 2;

    // Bit for pair (i,j), i < j, is set when way i was used before way j
    logic [LRU_BITS-1:0] older_q;
    logic [LRU_BITS-1:0] older_d;

    // Row-major position of pair (i,j) in the upper triangle
    function automatic int pair_idx(input int i, input int j);
        return i * NUM_WAYS - (i * (i + 1)) / 2 + (j - i - 1);
    endfunction

    // Touched way becomes newer than every other way
    always_comb begin
        older_d = older_q;
        for (int i = 0; i < NUM_WAYS; i++) begin
            for (int j = i + 1; j < NUM_WAYS; j++) begin
                if (touch_way_i == WAY_W'(i)) begin
                    older_d[pair_idx(i, j)] = 1'b0;
                end else if (touch_way_i == WAY_W'(j)) begin
                    older_d[pair_idx(i, j)] = 1'b1;
                end
            end
        end
    end

    // All ones gives way 0 oldest up to the last way newest
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            older_q <= '1;
        end else if (touch_i) begin
            older_q <= older_d;
        end
    end

    // Victim is the way older than all the others
    always_comb begin
        logic oldest;
        victim_way_o = '0;
        for (int v = NUM_WAYS - 1; v >= 0; v--) begin
            oldest = 1'b1;
            for (int k = 0; k < NUM_WAYS; k++) begin
                if (k < v) begin
                    if (older_q[pair_idx(k, v)]) begin
                        oldest = 1'b0;
                    end
                end else if (k > v) begin
                    if (!older_q[pair_idx(v, k)]) begin
                        oldest = 1'b0;
                    end
                end
            end
            if (oldest) begin
                victim_way_o = WAY_W'(v);
            end
        end
    end

endmodule

//--- hdl/mmu_fill_router.sv
`timescale 1ns/100ps

module mmu_fill_router
    import mmu_pkg::*;
#(
    parameter int DC_WAYS = 4,
    parameter int IC_WAYS = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       mm_data_rdy_i,
    input  line_t                      mm_data_i,
    input  req_owner_e                 owner_i,
    input  logic [$clog2(DC_WAYS)-1:0] dc_victim_i,
    input  logic [$clog2(IC_WAYS)-1:0] ic_victim_i,
    output logic                       dc_fill_rdy_o,
    output logic                       ic_fill_rdy_o,
    output line_t                      dc_fill_data_o,
    output line_t                      ic_fill_data_o,
    output logic [$clog2(DC_WAYS)-1:0] dc_fill_way_o,
    output logic [$clog2(IC_WAYS)-1:0] ic_fill_way_o
);

    logic dc_return;
    logic ic_return;

    assign dc_return = mm_data_rdy_i && (owner_i == OWNER_DCACHE);
    assign ic_return = mm_data_rdy_i && (owner_i == OWNER_ICACHE);

    // One-cycle pulse toward the owner, also touches its tracker
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dc_fill_rdy_o <= 1'b0;
            ic_fill_rdy_o <= 1'b0;
        end else begin
            dc_fill_rdy_o <= dc_return;
            ic_fill_rdy_o <= ic_return;
        end
    end

    // Line and victim held until the next fill for the same cache
    always_ff @(posedge clk_i) begin
        if (dc_return) begin
            dc_fill_data_o <= mm_data_i;
            dc_fill_way_o  <= dc_victim_i;
        end
        if (ic_return) begin
            ic_fill_data_o <= mm_data_i;
            ic_fill_way_o  <= ic_victim_i;
        end
    end

endmodule

//--- hdl/mmu_arbiter_fsm.sv
`timescale 1ns/100ps

module mmu_arbiter_fsm
    import mmu_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       dc_pending_i,
    input  logic       ic_pending_i,
    input  addr_t      dc_head_i,
    input  addr_t      ic_head_i,
    input  logic       mm_data_rdy_i,
    output logic       mm_rd_req_o,
    output addr_t      mm_addr_o,
    output req_owner_e owner_o,
    output logic       dc_pop_o,
    output logic       ic_pop_o
);

    mmu_state_e state_q;
    mmu_state_e state_d;
    // Set after a data fill so a waiting instruction miss goes next
    logic       ic_first_q;
    logic       pick_dc;
    logic       pick_ic;
    logic       start_dc;
    logic       start_ic;

    assign pick_dc = dc_pending_i && (!ic_pending_i || !ic_first_q);
    assign pick_ic = ic_pending_i && !pick_dc;

    assign start_dc = (state_q == IDLE) && pick_dc;
    assign start_ic = (state_q == IDLE) && pick_ic;

    // Served queue pops on the memory ready pulse
    assign dc_pop_o = (state_q == DC_WAIT) && mm_data_rdy_i;
    assign ic_pop_o = (state_q == IC_WAIT) && mm_data_rdy_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start_dc) begin
                    state_d = DC_REQ;
                end else if (start_ic) begin
                    state_d = IC_REQ;
                end
            end
            DC_REQ:  state_d = DC_WAIT;
            IC_REQ:  state_d = IC_WAIT;
            DC_WAIT, IC_WAIT: begin
                // Back through IDLE so the popped queue shows its new head
                if (mm_data_rdy_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= IDLE;
            ic_first_q  <= 1'b0;
            mm_rd_req_o <= 1'b0;
            owner_o     <= OWNER_DCACHE;
        end else begin
            state_q     <= state_d;
            mm_rd_req_o <= start_dc || start_ic;
            if (dc_pop_o) begin
                ic_first_q <= 1'b1;
            end else if (ic_pop_o || (state_q == IDLE && !dc_pending_i && !ic_pending_i)) begin
                ic_first_q <= 1'b0;
            end
            if (start_dc) begin
                owner_o <= OWNER_DCACHE;
            end else if (start_ic) begin
                owner_o <= OWNER_ICACHE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_dc) begin
            mm_addr_o <= dc_head_i;
        end else if (start_ic) begin
            mm_addr_o <= ic_head_i;
        end
    end

endmodule

//--- hdl/mmu_top.sv
`timescale 1ns/100ps

module mmu_top
    import mmu_pkg::*;
#(
    parameter int DC_WAYS = 4,
    parameter int IC_WAYS = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    // Data cache
    input  logic                       dc_miss_i,
    input  addr_t                      dc_addr_i,
    input  logic                       dc_access_i,
    input  logic [$clog2(DC_WAYS)-1:0] dc_hit_way_i,
    input  logic                       dc_writeback_i,
    input  line_t                      dc_wb_data_i,
    output logic                       dc_fill_rdy_o,
    output line_t                      dc_fill_data_o,
    output logic [$clog2(DC_WAYS)-1:0] dc_fill_way_o,
    // Instruction cache
    input  logic                       ic_miss_i,
    input  addr_t                      ic_addr_i,
    input  logic                       ic_access_i,
    input  logic [$clog2(IC_WAYS)-1:0] ic_hit_way_i,
    output logic                       ic_fill_rdy_o,
    output line_t                      ic_fill_data_o,
    output logic [$clog2(IC_WAYS)-1:0] ic_fill_way_o,
    // Main memory
    input  logic                       mm_data_rdy_i,
    input  line_t                      mm_data_i,
    output logic                       mm_rd_req_o,
    output addr_t                      mm_addr_o,
    output logic                       mm_wr_req_o,
    output addr_t                      mm_wr_addr_o,
    output line_t                      mm_wr_data_o
);

    logic                       dc_pending;
    logic                       ic_pending;
    addr_t                      dc_head;
    addr_t                      ic_head;
    logic                       dc_pop;
    logic                       ic_pop;
    req_owner_e                 owner;
    logic [$clog2(DC_WAYS)-1:0] dc_victim;
    logic [$clog2(IC_WAYS)-1:0] ic_victim;
    logic                       dc_touch;
    logic                       ic_touch;
    logic [$clog2(DC_WAYS)-1:0] dc_touch_way;
    logic [$clog2(IC_WAYS)-1:0] ic_touch_way;

    // Writebacks go straight to the memory write port
    assign mm_wr_req_o  = dc_writeback_i;
    assign mm_wr_addr_o = dc_addr_i;
    assign mm_wr_data_o = dc_wb_data_i;

    // A hit wins the tracker update over a fill in the same cycle
    assign dc_touch     = dc_access_i || dc_fill_rdy_o;
    assign ic_touch     = ic_access_i || ic_fill_rdy_o;
    assign dc_touch_way = dc_access_i ? dc_hit_way_i : dc_fill_way_o;
    assign ic_touch_way = ic_access_i ? ic_hit_way_i : ic_fill_way_o;

    mmu_miss_queue #(
        .QUEUE_DEPTH(2)
    ) dc_queue_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .miss_i      (dc_miss_i),
        .miss_addr_i (dc_addr_i),
        .pop_i       (dc_pop),
        .pending_o   (dc_pending),
        .head_addr_o (dc_head)
    );

    mmu_miss_queue #(
        .QUEUE_DEPTH(1)
    ) ic_queue_inst (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .miss_i      (ic_miss_i),
        .miss_addr_i (ic_addr_i),
        .pop_i       (ic_pop),
        .pending_o   (ic_pending),
        .head_addr_o (ic_head)
    );

    mmu_lru_tracker #(
        .NUM_WAYS(DC_WAYS)
    ) dc_lru_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .touch_i      (dc_touch),
        .touch_way_i  (dc_touch_way),
        .victim_way_o (dc_victim)
    );

    mmu_lru_tracker #(
        .NUM_WAYS(IC_WAYS)
    ) ic_lru_inst (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .touch_i      (ic_touch),
        .touch_way_i  (ic_touch_way),
        .victim_way_o (ic_victim)
    );

    mmu_fill_router #(
        .DC_WAYS(DC_WAYS),
        .IC_WAYS(IC_WAYS)
    ) fill_router_inst (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .mm_data_rdy_i  (mm_data_rdy_i),
        .mm_data_i      (mm_data_i),
        .owner_i        (owner),
        .dc_victim_i    (dc_victim),
        .ic_victim_i    (ic_victim),
        .dc_fill_rdy_o  (dc_fill_rdy_o),
        .ic_fill_rdy_o  (ic_fill_rdy_o),
        .dc_fill_data_o (dc_fill_data_o),
        .ic_fill_data_o (ic_fill_data_o),
        .dc_fill_way_o  (dc_fill_way_o),
        .ic_fill_way_o  (ic_fill_way_o)
    );

    mmu_arbiter_fsm arbiter_inst (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .dc_pending_i  (dc_pending),
        .ic_pending_i  (ic_pending),
        .dc_head_i     (dc_head),
        .ic_head_i     (ic_head),
        .mm_data_rdy_i (mm_data_rdy_i),
        .mm_rd_req_o   (mm_rd_req_o),
        .mm_addr_o     (mm_addr_o),
        .owner_o       (owner),
        .dc_pop_o      (dc_pop),
        .ic_pop_o      (ic_pop)
    );

endmodule

//--- verification/mmu_mem_model.sv
`timescale 1ns/100ps

module mmu_mem_model
    import mmu_pkg::*;
(
    input  logic  clk_i,
    input  logic  rd_req_i,
    input  addr_t addr_i,
    input  logic  wr_req_i,
    input  addr_t wr_addr_i,
    input  line_t wr_data_i,
    output logic  data_rdy_o,
    output line_t data_o
);

    logic [31:0] lfsr_state = 32'hba3ffa68;
    int          wr_count = 0;
    addr_t       last_wr_addr;
    line_t       last_wr_data;

    // Fixed content for every line
    function automatic line_t line_data(input addr_t addr);
        return {addr ^ 32'h5a5a_c3c3, ~addr, addr * 32'd3, {addr[15:0], addr[31:16]}};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    initial begin
        int lat;
        data_rdy_o = 1'b0;
        data_o     = '0;
        forever begin
            @(posedge clk_i);
            #1;
            if (rd_req_i) begin
                // Latency of 1 to 8 cycles
                lat = 1 + int'(rand_bits(3));
                repeat (lat) @(posedge clk_i);
                #1;
                data_rdy_o = 1'b1;
                data_o     = line_data(addr_i);
                @(posedge clk_i);
                #1;
                data_rdy_o = 1'b0;
            end
        end
    end

    // Write log
    always @(posedge clk_i) begin
        if (wr_req_i) begin
            wr_count++;
            last_wr_addr <= wr_addr_i;
            last_wr_data <= wr_data_i;
        end
    end

endmodule

//--- verification/mmu_tb.sv
`timescale 1ns/100ps

module mmu_tb
    import mmu_pkg::*;
;

    localparam int CLK_PERIOD = 10;
    localparam int MAX_REQ    = 64;
    localparam int MAX_LAT    = 8;
    localparam int MARGIN     = 400;
    localparam int TIMEOUT_NS = (MAX_REQ * MAX_LAT + MARGIN) * CLK_PERIOD;

    logic clk_i;
    logic rst_n_i;
    logic dc_miss, dc_access, dc_writeback, ic_miss, ic_access;
    addr_t dc_addr, ic_addr, mm_addr, mm_wr_addr;
    logic [1:0] dc_hit_way, ic_hit_way, dc_fill_way, ic_fill_way;
    line_t dc_wb_data, dc_fill_data, ic_fill_data, mm_data, mm_wr_data;
    logic dc_fill_rdy, ic_fill_rdy, mm_data_rdy, mm_rd_req, mm_wr_req;

    logic [31:0] lfsr_state = 32'hba3ffa68;
    int errors = 0;
    int test_base = 0;
    int rd_count = 0;

    // Reference state
    addr_t dc_q[$];
    addr_t ic_q[$];
    addr_t exp_rd_addr[$];
    addr_t exp_fill_addr[$];
    int exp_fill_owner[$];
    int exp_fill_way[$];
    int lru[2][4];
    int touch_pend[2];
    bit busy;
    bit last_dc;
    int cur_owner;
    addr_t cur_addr;

    mmu_top #(.DC_WAYS(4), .IC_WAYS(4)) mmu_top_inst (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .dc_miss_i(dc_miss), .dc_addr_i(dc_addr), .dc_access_i(dc_access),
        .dc_hit_way_i(dc_hit_way), .dc_writeback_i(dc_writeback), .dc_wb_data_i(dc_wb_data),
        .dc_fill_rdy_o(dc_fill_rdy), .dc_fill_data_o(dc_fill_data), .dc_fill_way_o(dc_fill_way),
        .ic_miss_i(ic_miss), .ic_addr_i(ic_addr), .ic_access_i(ic_access),
        .ic_hit_way_i(ic_hit_way),
        .ic_fill_rdy_o(ic_fill_rdy), .ic_fill_data_o(ic_fill_data), .ic_fill_way_o(ic_fill_way),
        .mm_data_rdy_i(mm_data_rdy), .mm_data_i(mm_data),
        .mm_rd_req_o(mm_rd_req), .mm_addr_o(mm_addr), .mm_wr_req_o(mm_wr_req),
        .mm_wr_addr_o(mm_wr_addr), .mm_wr_data_o(mm_wr_data)
    );

    mmu_mem_model mem_inst (
        .clk_i(clk_i), .rd_req_i(mm_rd_req), .addr_i(mm_addr),
        .wr_req_i(mm_wr_req), .wr_addr_i(mm_wr_addr), .wr_data_i(mm_wr_data),
        .data_rdy_o(mm_data_rdy), .data_o(mm_data)
    );

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[30:0], fb};
        end
        return val;
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[31:4], 4'h0};
    endfunction

    // A miss is kept unless its line is queued or the queue is full
    function automatic bit miss_accepted(input int c, input addr_t a);
        addr_t line;
        line = line_of(a);
        if (c == 0) begin
            foreach (dc_q[i]) if (dc_q[i] == line) return 1'b0;
            return dc_q.size() < 2;
        end
        foreach (ic_q[i]) if (ic_q[i] == line) return 1'b0;
        return ic_q.size() < 1;
    endfunction

    task automatic touch(input int c, input int way);
        int pos;
        pos = 0;
        for (int i = 0; i < 4; i++) begin
            if (lru[c][i] == way) pos = i;
        end
        for (int i = pos; i < 3; i++) begin
            lru[c][i] = lru[c][i + 1];
        end
        lru[c][3] = way;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish in %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $finish;
    end

    // Reference model, stepped on each edge from tb-driven inputs
    always @(posedge clk_i) begin : ref_step
        bit dc_take;
        bit ic_take;
        int fill_c;
        int fill_w;
        fill_c = -1;
        fill_w = 0;
        if (rst_n_i) begin
            dc_take = dc_miss && miss_accepted(0, dc_addr);
            ic_take = ic_miss && miss_accepted(1, ic_addr);
            if (busy && mm_data_rdy) begin
                fill_c = cur_owner;
                fill_w = lru[cur_owner][0];
                exp_fill_addr.push_back(cur_addr);
                exp_fill_owner.push_back(cur_owner);
                exp_fill_way.push_back(fill_w);
                if (cur_owner == 0) begin
                    void'(dc_q.pop_front());
                    last_dc = 1'b1;
                end else begin
                    void'(ic_q.pop_front());
                    last_dc = 1'b0;
                end
                busy = 1'b0;
            end else if (!busy && (dc_q.size() != 0 || ic_q.size() != 0)) begin
                cur_owner = (ic_q.size() != 0 && (dc_q.size() == 0 || last_dc)) ? 1 : 0;
                cur_addr  = (cur_owner == 1) ? ic_q[0] : dc_q[0];
                exp_rd_addr.push_back(cur_addr);
                busy = 1'b1;
            end else if (!busy) begin
                last_dc = 1'b0;
            end
            // A hit takes the tracker over a fill in the same cycle
            if (dc_access) touch(0, int'(dc_hit_way));
            else if (touch_pend[0] >= 0) touch(0, touch_pend[0]);
            if (ic_access) touch(1, int'(ic_hit_way));
            else if (touch_pend[1] >= 0) touch(1, touch_pend[1]);
            touch_pend[0] = -1;
            touch_pend[1] = -1;
            if (fill_c >= 0) touch_pend[fill_c] = fill_w;
            if (dc_take) dc_q.push_back(line_of(dc_addr));
            if (ic_take) ic_q.push_back(line_of(ic_addr));
        end
    end

    // Comparison on the falling edge where outputs are stable
    always @(negedge clk_i) begin : compare
        bit exp_dc;
        bit exp_ic;
        line_t data;
        int way;
        if (rst_n_i) begin
            assert (mm_rd_req == (exp_rd_addr.size() != 0)) else begin
                $display("Read request %s at %0t", mm_rd_req ? "not expected" : "missing", $time);
                errors++;
            end
            if (mm_rd_req && exp_rd_addr.size() != 0) begin
                rd_count++;
                assert (mm_addr == exp_rd_addr[0]) else begin
                    $display("FAILED mm_addr_o: got %h expected %h", mm_addr, exp_rd_addr[0]);
                    errors++;
                end
                void'(exp_rd_addr.pop_front());
            end
            exp_dc = exp_fill_owner.size() != 0 && exp_fill_owner[0] == 0;
            exp_ic = exp_fill_owner.size() != 0 && exp_fill_owner[0] == 1;
            assert (dc_fill_rdy == exp_dc && ic_fill_rdy == exp_ic) else begin
                $display("Fill pulse went to the wrong cache or was missing at %0t", $time);
                errors++;
            end
            if (exp_dc || exp_ic) begin
                data = exp_ic ? ic_fill_data : dc_fill_data;
                way  = exp_ic ? int'(ic_fill_way) : int'(dc_fill_way);
                assert (data == mem_inst.line_data(exp_fill_addr[0])) else begin
                    $display("FAILED %s_fill_data_o: got %h expected %h", exp_ic ? "ic" : "dc",
                             data, mem_inst.line_data(exp_fill_addr[0]));
                    errors++;
                end
                assert (way == exp_fill_way[0]) else begin
                    $display("FAILED %s_fill_way_o: got %h expected %h", exp_ic ? "ic" : "dc",
                             way, exp_fill_way[0]);
                    errors++;
                end
                void'(exp_fill_addr.pop_front());
                void'(exp_fill_owner.pop_front());
                void'(exp_fill_way.pop_front());
            end
            assert (mm_wr_req == dc_writeback) else begin
                $display("FAILED mm_wr_req_o: got %h expected %h", mm_wr_req, dc_writeback);
                errors++;
            end
            if (dc_writeback) begin
                assert (mm_wr_addr == dc_addr && mm_wr_data == dc_wb_data) else begin
                    $display("FAILED mm_wr_addr_o/mm_wr_data_o: got %h/%h expected %h/%h",
                             mm_wr_addr, mm_wr_data, dc_addr, dc_wb_data);
                    errors++;
                end
            end
        end
    end

    // One cycle of strobes, called 1 ns after an edge
    task automatic drive_cycle(input logic dm, input addr_t da, input logic im,
                               input addr_t ia, input logic dh, input logic ih,
                               input logic wb);
        dc_miss      = dm;
        dc_addr      = da;
        ic_miss      = im;
        ic_addr      = ia;
        dc_access    = dh;
        dc_hit_way   = rand_bits(2);
        ic_access    = ih;
        ic_hit_way   = rand_bits(2);
        dc_writeback = wb;
        dc_wb_data   = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
        @(posedge clk_i);
        #1;
        dc_miss      = 1'b0;
        ic_miss      = 1'b0;
        dc_access    = 1'b0;
        ic_access    = 1'b0;
        dc_writeback = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic drain();
        while (busy || dc_q.size() != 0 || ic_q.size() != 0 || exp_rd_addr.size() != 0 ||
               exp_fill_owner.size() != 0) begin
            wait_cycles(1);
        end
        wait_cycles(2);
    endtask

    task automatic report_test(input string name);
        $display("Test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        addr_t a;
        addr_t b;
        int reads_before;
        int writes_before;
        {dc_miss, dc_access, dc_writeback, ic_miss, ic_access} = '0;
        {dc_addr, ic_addr, dc_hit_way, ic_hit_way, dc_wb_data} = '0;
        for (int c = 0; c < 2; c++) begin
            for (int w = 0; w < 4; w++) lru[c][w] = w;
            touch_pend[c] = -1;
        end
        busy    = 1'b0;
        last_dc = 1'b0;
        rst_n_i = 1'b0;
        repeat (16) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        wait_cycles(1);

        drive_cycle(1, rand_bits(32), 0, '0, 0, 0, 0);
        drain();
        report_test("single_miss");

        drive_cycle(1, rand_bits(32), 1, rand_bits(32), 0, 0, 0);
        drain();
        repeat (10) begin
            drive_cycle(1, rand_bits(32), 1, rand_bits(32), 0, 0, 0);
            wait_cycles(int'(rand_bits(2)));
        end
        drain();
        report_test("arbitration");

        reads_before = rd_count;
        a = line_of(rand_bits(32));
        b = line_of(rand_bits(32));
        drive_cycle(1, a, 0, '0, 0, 0, 0);
        wait_cycles(1);
        // Same line as the read in flight, queue still has room
        drive_cycle(1, a + 32'd4, 0, '0, 0, 0, 0);
        drive_cycle(1, b, 0, '0, 0, 0, 0);
        drive_cycle(1, b + 32'd8, 0, '0, 0, 0, 0);
        drain();
        assert (rd_count - reads_before == 2) else begin
            $display("Merged misses issued %0d reads instead of 2", rd_count - reads_before);
            errors++;
        end
        report_test("queue_merge");

        repeat (16) begin
            drive_cycle(rand_bits(1), rand_bits(32), rand_bits(1), rand_bits(32),
                        rand_bits(1), rand_bits(1), 0);
        end
        drain();
        report_test("victim_order");

        writes_before = mem_inst.wr_count;
        drive_cycle(1, rand_bits(32), 0, '0, 0, 0, 0);
        wait_cycles(2);
        repeat (4) drive_cycle(0, rand_bits(32), 0, '0, 0, 0, 1);
        drain();
        assert (mem_inst.wr_count - writes_before == 4) else begin
            $display("Memory logged %0d writes instead of 4", mem_inst.wr_count - writes_before);
            errors++;
        end
        // Last logged write is the last one driven
        assert (mem_inst.last_wr_addr == dc_addr &&
                mem_inst.last_wr_data == dc_wb_data) else begin
            $display("FAILED mm_wr_addr_o/mm_wr_data_o logged: got %h/%h expected %h/%h",
                     mem_inst.last_wr_addr, mem_inst.last_wr_data, dc_addr, dc_wb_data);
            errors++;
        end
        report_test("writeback");

        $display("Tests done: 5 run, %0d failed checks", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
hdl/mmu_pkg.sv
hdl/mmu_miss_queue.sv
hdl/mmu_lru_tracker.sv
hdl/mmu_fill_router.sv
hdl/mmu_arbiter_fsm.sv
hdl/mmu_top.sv
verification/mmu_mem_model.sv
verification/mmu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run with Verilator, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module mmu_tb -f verilog.f -o mmu_sim \
    > build.log 2>&1 && ./obj_dir/mmu_sim > sim.log 2>&1 || { echo "Build or run error"; exit 1; }
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
